// File: source/mem_cfg_pkg.sv
//******************************
// memory configuration package
// word width, depth and address
// width of the FIFO storage RAM
//******************************

package mem_cfg_pkg;

   // width of one stored word
   localparam int DATA_W = 32;

   // number of words held by the RAM
   localparam int DEPTH = 16;

   // address width that covers every entry
   localparam int ADDR_W = $clog2(DEPTH);

   // one data word as it is written to and read from the RAM
   typedef logic [DATA_W-1:0] data_t;

   // RAM address
   typedef logic [ADDR_W-1:0] addr_t;

endpackage : mem_cfg_pkg

// File: source/fifo_ctl_pkg.sv
//******************************
// FIFO control package
// occupancy type and clock
// gating option of the FIFO
//******************************

package fifo_ctl_pkg;

   // one extra bit so the count can reach DEPTH itself
   localparam int COUNT_W = mem_cfg_pkg::ADDR_W + 1;

   // occupancy of the FIFO from 0 up to DEPTH
   typedef logic [COUNT_W-1:0] count_t;

   // 0 lets the port enables gate the RAM clock
   // 1 keeps the RAM clock running at all times
   localparam logic GATE_BYPASS = 1'b0;

endpackage : fifo_ctl_pkg

// File: source/mem_1r1w_sync_array.sv
//******************************
// 1r1w storage array
// one write port, one read port
// with a registered read
//******************************

`timescale 1ns/10ps

module mem_1r1w_sync_array
(
   // gated clock from the wrapper
   input  logic                clk_i,

   // write port
   input  logic                w_v_i,
   input  mem_cfg_pkg::addr_t  w_addr_i,
   input  mem_cfg_pkg::data_t  w_data_i,

   // read port
   input  logic                r_v_i,
   input  mem_cfg_pkg::addr_t  r_addr_i,
   output mem_cfg_pkg::data_t  r_data_o
);

   import mem_cfg_pkg::*;

   // storage words
   data_t mem_q [DEPTH];

   // write port stores the word on the edge
   always_ff @(posedge clk_i)
   begin
      if (w_v_i)
      begin
         mem_q[w_addr_i] <= w_data_i;
      end
   end

   // read port registers the addressed word
   // the output keeps its last value while no read is requested
   always_ff @(posedge clk_i)
   begin
      if (r_v_i)
      begin
         r_data_o <= mem_q[r_addr_i];
      end
   end

endmodule : mem_1r1w_sync_array

// File: source/mem_1r1w_sync.sv
//******************************
// 1r1w RAM with synchronous read
// gates its clock from the port
// enables around the array
//******************************

`timescale 1ns/10ps

module mem_1r1w_sync
(
   input  logic                clk_lo,
   input  logic                rst_n_i,

   // write port
   input  logic                w_v_i,
   input  mem_cfg_pkg::addr_t  w_addr_i,
   input  mem_cfg_pkg::data_t  w_data_i,

   // read port returns data one cycle after r_v_i
   input  logic                r_v_i,
   input  mem_cfg_pkg::addr_t  r_addr_i,
   output mem_cfg_pkg::data_t  r_data_o
);

   import mem_cfg_pkg::*;
   import fifo_ctl_pkg::*;

   logic clk_en;
   logic clk_en_latched;
   logic gated_clk;

   // the RAM only needs an edge when one of its ports is active
   assign clk_en = w_v_i | r_v_i | GATE_BYPASS;

   // latch is transparent while the clock is low
   // so the enable cannot glitch the high phase
   always_latch
   begin
      if (!clk_lo)
      begin
         clk_en_latched = clk_en;
      end
   end

   assign gated_clk = clk_lo & clk_en_latched;

   mem_1r1w_sync_array u_array
   (
      .clk_i    (gated_clk),
      .w_v_i    (w_v_i),
      .w_addr_i (w_addr_i),
      .w_data_i (w_data_i),
      .r_v_i    (r_v_i),
      .r_addr_i (r_addr_i),
      .r_data_o (r_data_o)
   );

   // a write must land inside the array
   a_w_addr_range : assert property
   (
      @(posedge clk_lo) disable iff (!rst_n_i)
      w_v_i |-> (w_addr_i < DEPTH)
   )
   else $error("write address %0h out of range for %0d words", w_addr_i, DEPTH);

   // read and write on one address in the same cycle would return stale data
   // the pointer logic upstream must never let that happen
   a_no_collision : assert property
   (
      @(posedge clk_lo) disable iff (!rst_n_i)
      !(w_v_i && r_v_i && (w_addr_i == r_addr_i))
   )
   else $error("read and write collide on address %0h", r_addr_i);

endmodule : mem_1r1w_sync

// File: source/fifo_ptr_ctrl.sv
//******************************
// FIFO pointer controller
// pointers, count, flags and
// read-valid for the FIFO RAM
//******************************

`timescale 1ns/10ps

module fifo_ptr_ctrl
(
   input  logic                  clk_lo,
   input  logic                  rst_n_i,

   // strobes from the FIFO user
   input  logic                  push_i,
   input  logic                  pop_i,
   input  mem_cfg_pkg::data_t    wr_data_i,

   // RAM write port
   output logic                  mem_w_v_o,
   output mem_cfg_pkg::addr_t    mem_w_addr_o,
   output mem_cfg_pkg::data_t    mem_w_data_o,

   // RAM read port
   output logic                  mem_r_v_o,
   output mem_cfg_pkg::addr_t    mem_r_addr_o,

   // status back to the FIFO user
   output logic                  rd_v_o,
   output logic                  full_o,
   output logic                  empty_o,
   output fifo_ctl_pkg::count_t  count_o
);

   import mem_cfg_pkg::*;
   import fifo_ctl_pkg::*;

   localparam addr_t LAST_ADDR = addr_t'(DEPTH - 1);

   logic   push_ok;
   logic   pop_ok;
   addr_t  wr_ptr_q;
   addr_t  rd_ptr_q;
   addr_t  wr_ptr_nxt;
   addr_t  rd_ptr_nxt;
   count_t count_nxt;

   // strobes against a full or empty FIFO are dropped here
   assign push_ok = push_i & ~full_o;
   assign pop_ok  = pop_i & ~empty_o;

   // pointers wrap at the last entry
   assign wr_ptr_nxt = (wr_ptr_q == LAST_ADDR) ? '0 : wr_ptr_q + 1'b1;
   assign rd_ptr_nxt = (rd_ptr_q == LAST_ADDR) ? '0 : rd_ptr_q + 1'b1;

   always_comb
   begin
      case ({push_ok, pop_ok})
         2'b10:   count_nxt = count_o + 1'b1;
         2'b01:   count_nxt = count_o - 1'b1;
         // push and pop together keep the count
         default: count_nxt = count_o;
      endcase
   end

   always_ff @(posedge clk_lo or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_o  <= '0;
         full_o   <= 1'b0;
         empty_o  <= 1'b1;
         rd_v_o   <= 1'b0;
      end
      else
      begin
         if (push_ok)
         begin
            wr_ptr_q <= wr_ptr_nxt;
         end
         if (pop_ok)
         begin
            rd_ptr_q <= rd_ptr_nxt;
         end
         count_o <= count_nxt;
         full_o  <= (count_nxt == count_t'(DEPTH));
         empty_o <= (count_nxt == '0);
         // RAM returns the word on the same edge this pulse rises
         rd_v_o  <= pop_ok;
      end
   end

   assign mem_w_v_o    = push_ok;
   assign mem_w_addr_o = wr_ptr_q;
   assign mem_w_data_o = wr_data_i;
   assign mem_r_v_o    = pop_ok;
   assign mem_r_addr_o = rd_ptr_q;

   a_count_max : assert property
   (
      @(posedge clk_lo) disable iff (!rst_n_i)
      count_o <= count_t'(DEPTH)
   )
   else $error("count %0d above depth %0d", count_o, DEPTH);

   a_flags_excl : assert property
   (
      @(posedge clk_lo) disable iff (!rst_n_i)
      !(full_o && empty_o)
   )
   else $error("full and empty both set");

endmodule : fifo_ptr_ctrl

// File: source/ram_fifo.sv
//******************************
// RAM based synchronous FIFO
// pointer controller in front
// of a 1r1w synchronous RAM
//******************************

`timescale 1ns/10ps

module ram_fifo
(
   input  logic                  clk_lo,
   input  logic                  rst_n_i,

   // write side
   input  logic                  push_i,
   input  mem_cfg_pkg::data_t    wr_data_i,

   // read side where data follows an accepted pop by one cycle
   input  logic                  pop_i,
   output mem_cfg_pkg::data_t    rd_data_o,
   output logic                  rd_v_o,

   // status
   output logic                  full_o,
   output logic                  empty_o,
   output fifo_ctl_pkg::count_t  count_o
);

   import mem_cfg_pkg::*;

   logic  mem_w_v;
   addr_t mem_w_addr;
   data_t mem_w_data;
   logic  mem_r_v;
   addr_t mem_r_addr;

   fifo_ptr_ctrl u_ctrl
   (
      .clk_lo       (clk_lo),
      .rst_n_i      (rst_n_i),
      .push_i       (push_i),
      .pop_i        (pop_i),
      .wr_data_i    (wr_data_i),
      .mem_w_v_o    (mem_w_v),
      .mem_w_addr_o (mem_w_addr),
      .mem_w_data_o (mem_w_data),
      .mem_r_v_o    (mem_r_v),
      .mem_r_addr_o (mem_r_addr),
      .rd_v_o       (rd_v_o),
      .full_o       (full_o),
      .empty_o      (empty_o),
      .count_o      (count_o)
   );

   // read data goes straight out and is qualified by rd_v_o
   mem_1r1w_sync u_mem
   (
      .clk_lo   (clk_lo),
      .rst_n_i  (rst_n_i),
      .w_v_i    (mem_w_v),
      .w_addr_i (mem_w_addr),
      .w_data_i (mem_w_data),
      .r_v_i    (mem_r_v),
      .r_addr_i (mem_r_addr),
      .r_data_o (rd_data_o)
   );

endmodule : ram_fifo

// File: dv/ram_fifo_tb.sv
//******************************
// RAM FIFO testbench
// replays the test file against
// a queue model of the FIFO
//******************************

`timescale 1ns/10ps

module ram_fifo_tb;

   import mem_cfg_pkg::*;
   import fifo_ctl_pkg::*;

   localparam string TEST_FILE  = "dv/ram_fifo_tests.txt";
   localparam int    RD_TIMEOUT = 8;
   localparam int    MAX_LINES  = 1000;

   logic   clk_lo;
   logic   rst_n_i;
   logic   push_i;
   logic   pop_i;
   data_t  wr_data_i;
   data_t  rd_data_o;
   logic   rd_v_o;
   logic   full_o;
   logic   empty_o;
   count_t count_o;

   integer seed = 32'h2619;

   // reference model of the FIFO contents
   data_t  model_q[$:DEPTH-1];

   ram_fifo u_ram_fifo
   (
      .clk_lo    (clk_lo),
      .rst_n_i   (rst_n_i),
      .push_i    (push_i),
      .wr_data_i (wr_data_i),
      .pop_i     (pop_i),
      .rd_data_o (rd_data_o),
      .rd_v_o    (rd_v_o),
      .full_o    (full_o),
      .empty_o   (empty_o),
      .count_o   (count_o)
   );

   initial
   begin
      clk_lo = 1'b0;
   end

   always #10 clk_lo = ~clk_lo;

   task automatic end_in_failure();
      $display("Test failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic report_mismatch(input string msg);
      $display("** Error at %0t ns: %s", $time, msg);
      end_in_failure();
   endtask

   task automatic report_problem(input string msg);
      $display("%s", msg);
      end_in_failure();
   endtask

   task automatic check_idle_state();
      assert (empty_o == 1'b1) else report_mismatch("empty_o low after reset");
      assert (full_o == 1'b0) else report_mismatch("full_o high after reset");
      assert (count_o == '0) else report_mismatch($sformatf("count_o %0d after reset", count_o));
      assert (rd_v_o == 1'b0) else report_mismatch("rd_v_o high after reset");
   endtask

   // reset is held over three rising edges and released on a falling edge
   task automatic apply_reset();
      push_i  = 1'b0;
      pop_i   = 1'b0;
      rst_n_i = 1'b0;
      repeat (3) @(negedge clk_lo);
      rst_n_i = 1'b1;
      model_q.delete();
      check_idle_state();
   endtask

   // one clock with the given strobes, then check flags, count and read data
   task automatic run_op(input logic do_push, input logic do_pop, input data_t word,
                         input int exp_count);
      logic  push_ok;
      logic  pop_ok;
      data_t exp_word;
      int    waited;
      push_ok  = do_push && (model_q.size() < DEPTH);
      pop_ok   = do_pop && (model_q.size() > 0);
      exp_word = '0;
      if (pop_ok)
      begin
         exp_word = model_q.pop_front();
      end
      if (push_ok)
      begin
         model_q.push_back(word);
      end
      push_i    = do_push;
      pop_i     = do_pop;
      wr_data_i = word;
      @(negedge clk_lo);
      push_i = 1'b0;
      pop_i  = 1'b0;
      if (model_q.size() != exp_count)
      begin
         report_problem($sformatf("test file expects count %0d but the model holds %0d",
                                  exp_count, model_q.size()));
      end
      assert (int'(count_o) == exp_count)
         else report_mismatch($sformatf("count_o %0d, expected %0d", count_o, exp_count));
      assert (full_o == (model_q.size() == DEPTH))
         else report_mismatch($sformatf("full_o %0b at count %0d", full_o, model_q.size()));
      assert (empty_o == (model_q.size() == 0))
         else report_mismatch($sformatf("empty_o %0b at count %0d", empty_o, model_q.size()));
      if (pop_ok)
      begin
         waited = 0;
         while (!rd_v_o && waited < RD_TIMEOUT)
         begin
            @(negedge clk_lo);
            waited++;
         end
         if (!rd_v_o)
         begin
            report_problem("the read-valid pulse never came after an accepted pop");
         end
         assert (waited == 0)
            else report_mismatch($sformatf("rd_v_o came %0d cycles late", waited));
         assert (rd_data_o == exp_word)
            else report_mismatch($sformatf("rd_data_o 0x%08h, expected 0x%08h",
                                           rd_data_o, exp_word));
      end
      else
      begin
         assert (rd_v_o == 1'b0) else report_mismatch("rd_v_o high without an accepted pop");
      end
   endtask

   initial
   begin
      int          fd;
      int          code;
      int          line_count;
      int          exp_count;
      logic [63:0] cmd;
      logic [1023:0] skip_buf;
      data_t       word;
      logic        done;
      rst_n_i   = 1'b0;
      push_i    = 1'b0;
      pop_i     = 1'b0;
      wr_data_i = '0;
      apply_reset();
      fd = $fopen(TEST_FILE, "r");
      if (fd == 0)
      begin
         report_problem($sformatf("could not open the test file %s", TEST_FILE));
      end
      done       = 1'b0;
      line_count = 0;
      while (!done && line_count < MAX_LINES)
      begin
         code = $fscanf(fd, "%s", cmd);
         if (code != 1)
         begin
            done = 1'b1;
         end
         else if (cmd == "#")
         begin
            code = $fgets(skip_buf, fd);
         end
         else
         begin
            line_count++;
            code = $fscanf(fd, "%h %d", word, exp_count);
            if (code != 2)
            begin
               report_problem($sformatf("operation %0d of the test file is malformed",
                                        line_count));
            end
            // a zero data word asks for a random one
            if (word == '0 && (cmd == "push" || cmd == "both"))
            begin
               word = $random(seed);
            end
            if (cmd == "push")
               run_op(1'b1, 1'b0, word, exp_count);
            else if (cmd == "pop")
               run_op(1'b0, 1'b1, word, exp_count);
            else if (cmd == "both")
               run_op(1'b1, 1'b1, word, exp_count);
            else if (cmd == "idle")
               run_op(1'b0, 1'b0, word, exp_count);
            else if (cmd == "reset")
               apply_reset();
            else
               report_problem($sformatf("unknown command %0s in the test file", cmd));
         end
      end
      $fclose(fd);
      if (line_count == 0)
      begin
         report_problem("the test file holds no operations");
      end
      $display("Test completed successfully");
      $finish;
   end

endmodule : ram_fifo_tb

// File: ram_fifo.f
source/mem_cfg_pkg.sv
source/fifo_ctl_pkg.sv
source/mem_1r1w_sync_array.sv
source/mem_1r1w_sync.sv
source/fifo_ptr_ctrl.sv
source/ram_fifo.sv
dv/ram_fifo_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the RAM FIFO testbench with Verilator and run it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f ram_fifo.f \
   --top-module ram_fifo_tb

sim_status=0
sim_output=$(./obj_dir/Vram_fifo_tb 2>&1) || sim_status=$?
echo "$sim_output"

# the testbench prints its pass line only when every check held
if grep -q "Test completed successfully" <<< "$sim_output"; then
   exit 0
fi

echo "simulation did not pass, exit status ${sim_status}"
exit 1

// File: dv/ram_fifo_tests.txt
# command  data word in hex (0 = random)  expected count after the edge
# commands are push, pop, both, reset and idle
idle  00000000  0
pop   00000000  0
push  a0000001  1
push  00000000  2
push  a0000003  3
push  00000000  4
push  a0000005  5
push  00000000  6
push  a0000007  7
push  00000000  8
push  a0000009  9
push  00000000  10
push  a000000b  11
push  00000000  12
push  a000000d  13
push  00000000  14
push  a000000f  15
push  00000000  16
push  deadbeef  16
pop   00000000  15
pop   00000000  14
pop   00000000  13
pop   00000000  12
both  b0000001  12
both  00000000  12
both  b0000003  12
both  00000000  12
both  b0000005  12
both  00000000  12
pop   00000000  11
pop   00000000  10
pop   00000000  9
pop   00000000  8
pop   00000000  7
pop   00000000  6
pop   00000000  5
pop   00000000  4
pop   00000000  3
pop   00000000  2
reset 00000000  0
idle  00000000  0
pop   00000000  0
push  c0000001  1
push  00000000  2
both  c0000003  2
pop   00000000  1
pop   00000000  0
